// ==== compile.f ====
+incdir+verilog
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/regFile.sv
verilog/aluOpDecode.sv
verilog/controlUnit.sv
verilog/decode.sv
testbench/tbClock.sv
testbench/decodeTb.sv

// ==== run.sh ====
#!/bin/sh
# build the decode stage testbench with verilator and run it
# a failing check ends in $fatal, which gives a nonzero exit status
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module decodeTb \
   -f compile.f \
   -o simDecode

./obj_dir/simDecode

// ==== testbench/decodeTb.sv ====
`timescale 1ns/1ps
`include "decode_cfg.svh"

// testbench for the decode stage
// plays writeback, mirrors the register file and checks with concurrent assertions
module decodeTb;

   localparam int NUM_RANDOM = 400;
   localparam int MAX_CYCLES = 600;   // 4 reset + 56 directed + 400 random, with margin
   localparam int DRIVE_DLY = 2;      // ns after the rising edge

   logic clk;
   logic rstN;

   // dut inputs
   logic [`DATA_W-1:0] instruction;
   logic instrValid;
   logic [`DATA_W-1:0] wbData;
   logic [`REG_SEL_W-1:0] wrtReg;
   logic regWrt;

   // dut outputs
   logic [`DATA_W-1:0] imm8, imm11, inA, inB, wrtData;
   logic [`REG_SEL_W-1:0] wrtRegOut;
   ctrlPkg::aluOpT aluOp;
   ctrlPkg::wbSelT wbDataSel;
   logic [2:0] brchSig;
   logic regWrtOut, aluJmp, slbiSel, createDump, memWrt, readEn, cin, invA, invB;
   logic immSrc, jalSel, sOpSel, aluPc, branchInst, err;

   // reference state and expected values
   logic [`DATA_W-1:0] refRegs [`NUM_REGS];
   logic [`DATA_W-1:0] gated;
   logic [4:0] op;
   logic isIfmt, isRfmt;
   logic [`DATA_W-1:0] expInA, expRegB, expInB, expWrtData, expImm8, expImm11;
   logic [`REG_SEL_W-1:0] expDest;
   logic expRegWrt, expMemWrt, expReadEn, expBranch, expErr, expDump, isAddOp;
   int cycleCount = 0;

   tbClock uClock (
      .clk  (clk),
      .rstN (rstN)
   );

   decode u_decode (.*);

   task automatic failNow(input string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic reportMismatch(input string name, input logic [`DATA_W-1:0] expVal,
                                 input logic [`DATA_W-1:0] gotVal);
      failNow($sformatf("Mismatch at time %0t: %s expected %h, DUT %h",
                        $time, name, expVal, gotVal));
   endtask

   // one clock of stimulus, applied just after the edge
   task automatic driveCycle(input logic [`DATA_W-1:0] instr, input logic valid,
                             input logic wrEn, input logic [`REG_SEL_W-1:0] wrSel,
                             input logic [`DATA_W-1:0] wrVal);
      @(posedge clk);
      #DRIVE_DLY;
      instruction = instr;
      instrValid = valid;
      regWrt = wrEn;
      wrtReg = wrSel;
      wbData = wrVal;
   endtask

   // store word, reads rs on inA and rt on the store data path
   function automatic logic [`DATA_W-1:0] stWord(input int rs, input int rt);
      return {isaPkg::ST, 3'(rs), 3'(rt), 5'd0};
   endfunction

   function automatic logic [4:0] drawLegalOpcode();
      logic [4:0] o;
      o = 5'($urandom);
      while (o inside {5'b00010, 5'b00011})
         o = 5'($urandom);   // the two holes in the table
      return o;
   endfunction

   // reference register file, written on the edge like the real one
   always @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `NUM_REGS; i++)
            refRegs[i] <= '0;
      end else if (regWrt) begin
         refRegs[wrtReg] <= wbData;
      end
   end

   always_comb begin
      gated = instrValid ? instruction : `NOP_INSTR;   // bubble reads as nop
      op = gated[15:11];
      isIfmt = op inside {isaPkg::ADDI, isaPkg::SUBI, isaPkg::XORI, isaPkg::ANDNI,
                          isaPkg::ROLI, isaPkg::SLLI, isaPkg::RORI, isaPkg::SRLI};
      isRfmt = op inside {isaPkg::ARITH, isaPkg::SHIFT, isaPkg::BTR, isaPkg::SEQ,
                          isaPkg::SLT, isaPkg::SLE, isaPkg::SCO};
      // read selects use the raw word even on a bubble
      expInA = refRegs[instruction[10:8]];
      expRegB = refRegs[instruction[7:5]];
      expImm11 = {{(`DATA_W-11){gated[10]}}, gated[10:0]};
      if (op inside {isaPkg::SLBI, isaPkg::XORI, isaPkg::ANDNI})
         expImm8 = {{(`DATA_W-8){1'b0}}, gated[7:0]};   // logic imms zero extend
      else
         expImm8 = {{(`DATA_W-8){gated[7]}}, gated[7:0]};
      if (op inside {isaPkg::XORI, isaPkg::ANDNI})
         expInB = {{(`DATA_W-5){1'b0}}, gated[4:0]};
      else if (isIfmt || op inside {isaPkg::LD, isaPkg::STU})
         expInB = {{(`DATA_W-5){gated[4]}}, gated[4:0]};
      else if (gated[15:13] inside {3'b001, 3'b011} || op inside {isaPkg::LBI, isaPkg::SLBI})
         expInB = '0;        // jumps, branches, byte loads
      else
         expInB = expRegB;   // r-format, st, halt, nop, illegal
      expWrtData = (op == isaPkg::STU) ? expRegB : expInB;
      if (isRfmt)
         expDest = gated[4:2];
      else if (isIfmt || op == isaPkg::LD)
         expDest = gated[7:5];
      else if (op inside {isaPkg::LBI, isaPkg::SLBI, isaPkg::STU})
         expDest = gated[10:8];
      else
         expDest = 3'd7;     // jal, jalr link
      expRegWrt = isIfmt || isRfmt || op inside {isaPkg::LD, isaPkg::STU, isaPkg::LBI,
                                                 isaPkg::SLBI, isaPkg::JAL, isaPkg::JALR};
      expMemWrt = op inside {isaPkg::ST, isaPkg::STU};
      expReadEn = (op == isaPkg::LD);
      expBranch = gated[15:13] inside {3'b001, 3'b011};
      expErr = op inside {5'b00010, 5'b00011};
      expDump = (op == isaPkg::HALT);
      isAddOp = op inside {isaPkg::ADDI, isaPkg::LD, isaPkg::ST};
   end

   chkInA: assert property (@(posedge clk) disable iff (!rstN) inA == expInA)
      else reportMismatch("inA", $sampled(expInA), $sampled(inA));
   chkInB: assert property (@(posedge clk) disable iff (!rstN) inB == expInB)
      else reportMismatch("inB", $sampled(expInB), $sampled(inB));
   chkWrtData: assert property (@(posedge clk) disable iff (!rstN) wrtData == expWrtData)
      else reportMismatch("wrtData", $sampled(expWrtData), $sampled(wrtData));
   chkImm8: assert property (@(posedge clk) disable iff (!rstN) imm8 == expImm8)
      else reportMismatch("imm8", $sampled(expImm8), $sampled(imm8));
   chkImm11: assert property (@(posedge clk) disable iff (!rstN) imm11 == expImm11)
      else reportMismatch("imm11", $sampled(expImm11), $sampled(imm11));
   chkDest: assert property (@(posedge clk) disable iff (!rstN)
      expRegWrt |-> wrtRegOut == expDest)
      else reportMismatch("wrtRegOut", 16'($sampled(expDest)), 16'($sampled(wrtRegOut)));
   chkRegWrt: assert property (@(posedge clk) disable iff (!rstN) regWrtOut == expRegWrt)
      else reportMismatch("regWrtOut", 16'($sampled(expRegWrt)), 16'($sampled(regWrtOut)));
   chkMemWrt: assert property (@(posedge clk) disable iff (!rstN) memWrt == expMemWrt)
      else reportMismatch("memWrt", 16'($sampled(expMemWrt)), 16'($sampled(memWrt)));
   chkReadEn: assert property (@(posedge clk) disable iff (!rstN) readEn == expReadEn)
      else reportMismatch("readEn", 16'($sampled(expReadEn)), 16'($sampled(readEn)));
   chkBranch: assert property (@(posedge clk) disable iff (!rstN) branchInst == expBranch)
      else reportMismatch("branchInst", 16'($sampled(expBranch)), 16'($sampled(branchInst)));
   chkErr: assert property (@(posedge clk) disable iff (!rstN) err == expErr)
      else reportMismatch("err", 16'($sampled(expErr)), 16'($sampled(err)));
   chkDump: assert property (@(posedge clk) disable iff (!rstN) createDump == expDump)
      else reportMismatch("createDump", 16'($sampled(expDump)), 16'($sampled(createDump)));
   chkAluAdd: assert property (@(posedge clk) disable iff (!rstN)
      isAddOp |-> aluOp == ctrlPkg::ALU_ADD)
      else reportMismatch("aluOp", 16'(ctrlPkg::ALU_ADD), 16'($sampled(aluOp)));
   // a bubble must look exactly like a nop downstream
   chkBubble: assert property (@(posedge clk) disable iff (!rstN)
      !instrValid |-> !(memWrt || regWrtOut || readEn || aluJmp || jalSel || createDump ||
                        branchInst || err || cin || invA || invB || slbiSel || immSrc ||
                        sOpSel || aluPc) && brchSig == ctrlPkg::BR_NONE &&
                      wbDataSel == ctrlPkg::WB_ALU)
      else failNow("a control strobe was active during a cycle with instrValid low");

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= MAX_CYCLES)
         failNow("timeout: the stimulus did not finish within the cycle limit");
   end

   initial begin
      int kind;
      logic [`DATA_W-1:0] word;
      instruction = `NOP_INSTR;
      instrValid = 1'b0;   // nop during reset
      wbData = '0;
      wrtReg = '0;
      regWrt = 1'b0;
      void'($urandom(32'hd9824a6f));
      wait (rstN);

      // every register reads zero after reset
      for (int r = 0; r < `NUM_REGS; r++)
         driveCycle(stWord(r, r), 1'b1, 1'b0, 3'd0, 16'd0);
      // write each register while reading it, old value expected that cycle
      for (int r = 0; r < `NUM_REGS; r++)
         driveCycle(stWord(r, r), 1'b1, 1'b1, 3'(r), 16'($urandom));
      for (int r = 0; r < `NUM_REGS; r++)
         driveCycle(stWord(r, `NUM_REGS - 1 - r), 1'b1, 1'b0, 3'd0, 16'd0);
      // every opcode once, holes included
      for (int o = 0; o < 32; o++)
         driveCycle({5'(o), 11'($urandom)}, 1'b1, 1'b0, 3'd0, 16'd0);

      // random mix of legal, illegal and bubble cycles with writes interleaved
      for (int n = 0; n < NUM_RANDOM; n++) begin
         kind = $urandom_range(15, 0);
         word = 16'($urandom);
         if (kind == 0)
            word[15:11] = {4'b0001, 1'($urandom)};
         else
            word[15:11] = drawLegalOpcode();
         driveCycle(word, kind != 1, 1'($urandom), 3'($urandom), 16'($urandom));
      end

      driveCycle(`NOP_INSTR, 1'b0, 1'b0, 3'd0, 16'd0);
      @(posedge clk);
      #1;   // let the last edge's assertions finish
      $display("PASS: all tests");
      $finish;
   end

endmodule

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps

// free running clock with a 20 ns period
// rstN is held low over the first four rising edges
module tbClock (
   output logic clk,
   output logic rstN
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      rstN = 1'b0;
      repeat (4) @(posedge clk);
      #2 rstN = 1'b1;   // released off the edge like every other input
   end

endmodule

// ==== verilog/decode.sv ====
`timescale 1ns/1ps
`include "decode_cfg.svh"

// decode stage: gating, immediates, operand muxes, register file
// fully combinational apart from the register file write
module decode (
   input  logic                  clk,
   input  logic                  rstN,
   input  logic [`DATA_W-1:0]    instruction,
   input  logic                  instrValid,
   input  logic [`DATA_W-1:0]    wbData,      // writeback port
   input  logic [`REG_SEL_W-1:0] wrtReg,
   input  logic                  regWrt,
   output logic [`DATA_W-1:0]    imm8,
   output logic [`DATA_W-1:0]    imm11,
   output logic [`DATA_W-1:0]    inA,         // rs
   output logic [`DATA_W-1:0]    inB,         // alu b after bSrc mux
   output logic [`DATA_W-1:0]    wrtData,     // store data
   output logic [`REG_SEL_W-1:0] wrtRegOut,
   output logic                  regWrtOut,
   output ctrlPkg::aluOpT        aluOp,
   output logic                  aluJmp,
   output logic                  slbiSel,
   output logic                  createDump,
   output logic                  memWrt,
   output logic                  readEn,
   output logic [2:0]            brchSig,
   output logic                  cin,
   output logic                  invA,
   output logic                  invB,
   output ctrlPkg::wbSelT        wbDataSel,
   output logic                  immSrc,
   output logic                  jalSel,
   output logic                  sOpSel,
   output logic                  aluPc,
   output logic                  branchInst,
   output logic                  err
);

   localparam int IMM5_W = isaPkg::IMM5_HI + 1;
   localparam int IMM8_W = isaPkg::IMM8_HI + 1;
   localparam int IMM11_W = isaPkg::IMM11_HI + 1;

   logic [`DATA_W-1:0] inst;      // instruction after valid gating
   logic [`DATA_W-1:0] imm5;
   logic [`DATA_W-1:0] regB;      // rt read port
   ctrlPkg::bSrcT bSrc;
   ctrlPkg::destSelT destSel;
   logic zeroSel;
   logic stuSel;
   logic [2:0] opcTop;            // opcode bits 15:13

   assign inst = instrValid ? instruction : `NOP_INSTR;   // bubble becomes a nop

   // immediates, imm11 is always signed
   assign imm5 = zeroSel ? {{(`DATA_W-IMM5_W){1'b0}}, inst[isaPkg::IMM5_HI:0]}
                         : {{(`DATA_W-IMM5_W){inst[isaPkg::IMM5_HI]}}, inst[isaPkg::IMM5_HI:0]};
   assign imm8 = zeroSel ? {{(`DATA_W-IMM8_W){1'b0}}, inst[isaPkg::IMM8_HI:0]}
                         : {{(`DATA_W-IMM8_W){inst[isaPkg::IMM8_HI]}}, inst[isaPkg::IMM8_HI:0]};
   assign imm11 = {{(`DATA_W-IMM11_W){inst[isaPkg::IMM11_HI]}}, inst[isaPkg::IMM11_HI:0]};

   // read selects from the raw word, their data is don't care on a bubble
   regFile uRegFile (
      .clk         (clk),
      .rstN        (rstN),
      .read1RegSel (instruction[isaPkg::RS_HI:isaPkg::RS_LO]),
      .read2RegSel (instruction[isaPkg::RT_HI:isaPkg::RT_LO]),
      .writeRegSel (wrtReg),
      .writeData   (wbData),
      .writeEn     (regWrt),
      .read1Data   (inA),
      .read2Data   (regB)
   );

   always_comb begin
      case (bSrc)
         ctrlPkg::B_REG:   inB = regB;
         ctrlPkg::B_IMM5:  inB = imm5;
         ctrlPkg::B_IMM11: inB = imm11;
         default:          inB = '0;
      endcase
   end

   assign wrtData = stuSel ? regB : inB;   // stu stores rt while inB holds the offset

   always_comb begin
      case (destSel)
         ctrlPkg::DST_RS: wrtRegOut = inst[isaPkg::RS_HI:isaPkg::RS_LO];
         ctrlPkg::DST_RT: wrtRegOut = inst[isaPkg::RT_HI:isaPkg::RT_LO];
         ctrlPkg::DST_RD: wrtRegOut = inst[isaPkg::RD_HI:isaPkg::RD_LO];
         default:         wrtRegOut = 3'd7;   // link register
      endcase
   end

   controlUnit uControlUnit (
      .instruction (inst),
      .aluJmp      (aluJmp),
      .memWrt      (memWrt),
      .brchSig     (brchSig),
      .cin         (cin),
      .invA        (invA),
      .invB        (invB),
      .regWrt      (regWrtOut),
      .wbDataSel   (wbDataSel),
      .stuSel      (stuSel),
      .immSrc      (immSrc),
      .slbiSel     (slbiSel),
      .createDump  (createDump),
      .bSrc        (bSrc),
      .zeroSel     (zeroSel),
      .regDestSel  (destSel),
      .jalSel      (jalSel),
      .sOpSel      (sOpSel),
      .aluPc       (aluPc),
      .err         (err)
   );

   aluOpDecode uAluOpDecode (
      .instruction (inst),
      .aluOp       (aluOp)
   );

   assign readEn = (wbDataSel == ctrlPkg::WB_MEM);   // only loads read memory

   // jumps are 001xx, conditional branches 011xx
   assign opcTop = inst[isaPkg::OPC_HI:isaPkg::OPC_HI-2];
   assign branchInst = (opcTop == 3'b001) || (opcTop == 3'b011);

endmodule

// ==== verilog/controlUnit.sv ====
`timescale 1ns/1ps

// main decoder, one case on the opcode
// an opcode outside the table raises err and writes nothing
module controlUnit (
   input  logic [isaPkg::OPC_HI:0] instruction,
   output logic                    aluJmp,      // target is rs + imm8 from the alu
   output logic                    memWrt,
   output ctrlPkg::brchT           brchSig,
   output logic                    cin,         // adder carry in
   output logic                    invA,
   output logic                    invB,
   output logic                    regWrt,
   output ctrlPkg::wbSelT          wbDataSel,
   output logic                    stuSel,      // store data from rt, inB carries imm5
   output logic                    immSrc,      // pc offset, 0 imm8, 1 imm11
   output logic                    slbiSel,
   output logic                    createDump,  // halt
   output ctrlPkg::bSrcT           bSrc,
   output logic                    zeroSel,     // zero extend imm5 and imm8
   output ctrlPkg::destSelT        regDestSel,
   output logic                    jalSel,      // link write of pc + 2
   output logic                    sOpSel,      // result from the shifter
   output logic                    aluPc,       // pc relative target
   output logic                    err
);

   isaPkg::opcodeT opc;
   isaPkg::opClassT cls;
   logic [1:0] func;

   assign opc = isaPkg::opcodeT'(instruction[isaPkg::OPC_HI:isaPkg::OPC_LO]);
   assign func = instruction[isaPkg::FUNC_HI:isaPkg::FUNC_LO];

   always_comb begin
      // defaults are a nop, each opcode only raises what it needs
      aluJmp = 1'b0;
      memWrt = 1'b0;
      brchSig = ctrlPkg::BR_NONE;
      cin = 1'b0;
      invA = 1'b0;
      invB = 1'b0;
      regWrt = 1'b0;
      wbDataSel = ctrlPkg::WB_ALU;
      stuSel = 1'b0;
      immSrc = 1'b0;
      slbiSel = 1'b0;
      createDump = 1'b0;
      bSrc = ctrlPkg::B_REG;
      zeroSel = 1'b0;
      regDestSel = ctrlPkg::DST_RD;
      jalSel = 1'b0;
      sOpSel = 1'b0;
      aluPc = 1'b0;
      cls = isaPkg::CLS_ILLEGAL;

      case (opc)
         isaPkg::HALT: begin
            createDump = 1'b1;
            cls = isaPkg::CLS_SYS;
         end
         isaPkg::NOP: cls = isaPkg::CLS_SYS;
         isaPkg::ADDI, isaPkg::SUBI, isaPkg::XORI, isaPkg::ANDNI,
         isaPkg::ROLI, isaPkg::SLLI, isaPkg::RORI, isaPkg::SRLI: begin
            regWrt = 1'b1;
            bSrc = ctrlPkg::B_IMM5;
            regDestSel = ctrlPkg::DST_RT;
            zeroSel = (opc == isaPkg::XORI) || (opc == isaPkg::ANDNI);   // logic imms
            invA = (opc == isaPkg::SUBI);    // imm - rs
            cin = (opc == isaPkg::SUBI);
            invB = (opc == isaPkg::ANDNI);
            sOpSel = opc[2];                 // 101xx are the shifts
            cls = isaPkg::CLS_IFMT;
         end
         isaPkg::ST: begin
            memWrt = 1'b1;                   // store data rides on inB
            cls = isaPkg::CLS_MEM;
         end
         isaPkg::LD: begin
            regWrt = 1'b1;
            bSrc = ctrlPkg::B_IMM5;
            regDestSel = ctrlPkg::DST_RT;
            wbDataSel = ctrlPkg::WB_MEM;
            cls = isaPkg::CLS_MEM;
         end
         isaPkg::STU: begin
            memWrt = 1'b1;
            regWrt = 1'b1;                   // rs gets the updated address
            stuSel = 1'b1;
            bSrc = ctrlPkg::B_IMM5;
            regDestSel = ctrlPkg::DST_RS;
            cls = isaPkg::CLS_MEM;
         end
         isaPkg::ARITH, isaPkg::SHIFT, isaPkg::BTR,
         isaPkg::SEQ, isaPkg::SLT, isaPkg::SLE, isaPkg::SCO: begin
            regWrt = 1'b1;
            if (opc == isaPkg::ARITH) begin
               invA = (func == 2'b01);       // rt - rs
               cin = (func == 2'b01);
               invB = (func == 2'b11);       // andn
            end
            if (opc == isaPkg::SEQ || opc == isaPkg::SLT || opc == isaPkg::SLE) begin
               invB = 1'b1;                  // compares look at rs - rt
               cin = 1'b1;
            end
            sOpSel = (opc == isaPkg::SHIFT);
            cls = isaPkg::CLS_RFMT;
         end
         isaPkg::BEQZ, isaPkg::BNEZ, isaPkg::BLTZ, isaPkg::BGEZ: begin
            bSrc = ctrlPkg::B_ZERO;          // rs + 0 feeds the condition
            case (opc)
               isaPkg::BEQZ: brchSig = ctrlPkg::BR_EQZ;
               isaPkg::BNEZ: brchSig = ctrlPkg::BR_NEZ;
               isaPkg::BLTZ: brchSig = ctrlPkg::BR_LTZ;
               default: brchSig = ctrlPkg::BR_GEZ;
            endcase
            cls = isaPkg::CLS_BRANCH;
         end
         isaPkg::LBI, isaPkg::SLBI: begin
            regWrt = 1'b1;
            bSrc = ctrlPkg::B_ZERO;
            regDestSel = ctrlPkg::DST_RS;
            slbiSel = (opc == isaPkg::SLBI);
            zeroSel = (opc == isaPkg::SLBI);  // slbi fills the low byte unsigned
            wbDataSel = (opc == isaPkg::LBI) ? ctrlPkg::WB_IMM : ctrlPkg::WB_ALU;
            cls = isaPkg::CLS_IMM;
         end
         isaPkg::J, isaPkg::JR, isaPkg::JAL, isaPkg::JALR: begin
            brchSig = ctrlPkg::BR_UNCOND;
            bSrc = ctrlPkg::B_ZERO;
            aluJmp = opc[0];                 // jr, jalr add imm8 to rs
            immSrc = !opc[0];                // j, jal use imm11
            aluPc = !opc[0];
            regWrt = opc[1];                 // jal, jalr link into r7
            jalSel = opc[1];
            if (opc[1]) begin
               regDestSel = ctrlPkg::DST_R7;
               wbDataSel = ctrlPkg::WB_PC2;
            end
            cls = isaPkg::CLS_JUMP;
         end
         default: cls = isaPkg::CLS_ILLEGAL;   // write strobes stay at their defaults
      endcase

      err = (cls == isaPkg::CLS_ILLEGAL);

      // only stu both writes memory and a register
      stuOnly: assert (!(memWrt && regWrt) || opc == isaPkg::STU)
         else $error("memWrt and regWrt both high for opcode %b", opc);
   end

endmodule

// ==== verilog/aluOpDecode.sv ====
`timescale 1ns/1ps

// opcode to alu operation
// ARITH and SHIFT pick their op from the two function bits
module aluOpDecode (
   input  logic [isaPkg::OPC_HI:0] instruction,
   output ctrlPkg::aluOpT          aluOp
);

   isaPkg::opcodeT opc;
   logic [1:0] func;

   assign opc = isaPkg::opcodeT'(instruction[isaPkg::OPC_HI:isaPkg::OPC_LO]);
   assign func = instruction[isaPkg::FUNC_HI:isaPkg::FUNC_LO];

   always_comb begin
      aluOp = ctrlPkg::ALU_ADD;   // loads, stores, branch and jump targets
      case (opc)
         isaPkg::SUBI:  aluOp = ctrlPkg::ALU_SUB;
         isaPkg::XORI:  aluOp = ctrlPkg::ALU_XOR;
         isaPkg::ANDNI: aluOp = ctrlPkg::ALU_ANDN;
         isaPkg::ROLI:  aluOp = ctrlPkg::ALU_ROL;
         isaPkg::SLLI:  aluOp = ctrlPkg::ALU_SLL;
         isaPkg::RORI:  aluOp = ctrlPkg::ALU_ROR;
         isaPkg::SRLI:  aluOp = ctrlPkg::ALU_SRL;
         isaPkg::ARITH: begin
            case (func)
               2'b00: aluOp = ctrlPkg::ALU_ADD;
               2'b01: aluOp = ctrlPkg::ALU_SUB;
               2'b10: aluOp = ctrlPkg::ALU_XOR;
               default: aluOp = ctrlPkg::ALU_ANDN;
            endcase
         end
         isaPkg::SHIFT: begin
            case (func)
               2'b00: aluOp = ctrlPkg::ALU_ROL;
               2'b01: aluOp = ctrlPkg::ALU_SLL;
               2'b10: aluOp = ctrlPkg::ALU_ROR;
               default: aluOp = ctrlPkg::ALU_SRL;
            endcase
         end
         isaPkg::SEQ:   aluOp = ctrlPkg::ALU_SEQ;
         isaPkg::SLT:   aluOp = ctrlPkg::ALU_SLT;
         isaPkg::SLE:   aluOp = ctrlPkg::ALU_SLE;
         isaPkg::SCO:   aluOp = ctrlPkg::ALU_SCO;
         isaPkg::BTR:   aluOp = ctrlPkg::ALU_BTR;
         isaPkg::LBI:   aluOp = ctrlPkg::ALU_PASSB;   // imm8 straight through
         isaPkg::SLBI:  aluOp = ctrlPkg::ALU_SLL;     // rs << 8, imm8 or'd in by slbiSel
         default:       aluOp = ctrlPkg::ALU_ADD;
      endcase
   end

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps
`include "decode_cfg.svh"

// eight word register file
// two combinational read ports, one write port on the rising edge
// a read of the register being written returns the old value this cycle
module regFile (
   input  logic                  clk,
   input  logic                  rstN,
   input  logic [`REG_SEL_W-1:0] read1RegSel,   // rs
   input  logic [`REG_SEL_W-1:0] read2RegSel,   // rt
   input  logic [`REG_SEL_W-1:0] writeRegSel,
   input  logic [`DATA_W-1:0]    writeData,
   input  logic                  writeEn,
   output logic [`DATA_W-1:0]    read1Data,
   output logic [`DATA_W-1:0]    read2Data
);

   logic [`DATA_W-1:0] regs [`NUM_REGS];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;   // every register starts at zero
         end
      end else if (writeEn) begin
         regs[writeRegSel] <= writeData;
      end
   end

   // stored contents only, the writer sees its data next cycle
   assign read1Data = regs[read1RegSel];
   assign read2Data = regs[read2RegSel];

   // writeback stage must never commit x into the file
   wrDataKnown: assert property (
      @(posedge clk) disable iff (!rstN)
      writeEn |-> !$isunknown(writeData)
   ) else $error("register write with unknown data, reg %0d", writeRegSel);

endmodule

// ==== verilog/ctrlPkg.sv ====
package ctrlPkg;

   // source of alu input b
   typedef enum logic [1:0] {
      B_REG = 2'b00,     // second register read port
      B_IMM5 = 2'b01,
      B_IMM11 = 2'b10,
      B_ZERO = 2'b11     // branches and jumps compare or add against zero
   } bSrcT;

   // which field names the register written back
   typedef enum logic [1:0] {
      DST_RS = 2'b00,    // bits 10:8
      DST_RT = 2'b01,    // bits 7:5
      DST_RD = 2'b10,    // bits 4:2
      DST_R7 = 2'b11     // link register
   } destSelT;

   // writeback data source, picked in the wb stage
   typedef enum logic [1:0] {
      WB_ALU = 2'b00,
      WB_MEM = 2'b01,
      WB_PC2 = 2'b10,
      WB_IMM = 2'b11
   } wbSelT;

   // branch condition tested on rs in execute
   typedef enum logic [2:0] {
      BR_NONE = 3'd0,
      BR_EQZ = 3'd1,
      BR_NEZ = 3'd2,
      BR_LTZ = 3'd3,
      BR_GEZ = 3'd4,
      BR_UNCOND = 3'd5
   } brchT;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN,
      ALU_ROL, ALU_SLL, ALU_ROR, ALU_SRL,
      ALU_SEQ, ALU_SLT, ALU_SLE, ALU_SCO,
      ALU_BTR, ALU_PASSB
   } aluOpT;

endpackage

// ==== verilog/isaPkg.sv ====
package isaPkg;

   // instruction field positions, msb first
   localparam int OPC_HI = 15;
   localparam int OPC_LO = 11;
   localparam int RS_HI = 10;      // first source, also dest of lbi/slbi/stu
   localparam int RS_LO = 8;
   localparam int RT_HI = 7;       // second source, dest of i-format
   localparam int RT_LO = 5;
   localparam int RD_HI = 4;       // dest of r-format
   localparam int RD_LO = 2;
   localparam int FUNC_HI = 1;     // selects the op inside ARITH and SHIFT
   localparam int FUNC_LO = 0;
   localparam int IMM5_HI = 4;
   localparam int IMM8_HI = 7;
   localparam int IMM11_HI = 10;

   // opcodes 00010 and 00011 are not in the table and decode as illegal
   typedef enum logic [4:0] {
      HALT = 5'b00000, NOP = 5'b00001,
      J = 5'b00100, JR = 5'b00101, JAL = 5'b00110, JALR = 5'b00111,
      ADDI = 5'b01000, SUBI = 5'b01001, XORI = 5'b01010, ANDNI = 5'b01011,
      BEQZ = 5'b01100, BNEZ = 5'b01101, BLTZ = 5'b01110, BGEZ = 5'b01111,
      ST = 5'b10000, LD = 5'b10001, SLBI = 5'b10010, STU = 5'b10011,
      ROLI = 5'b10100, SLLI = 5'b10101, RORI = 5'b10110, SRLI = 5'b10111,
      LBI = 5'b11000, BTR = 5'b11001, SHIFT = 5'b11010, ARITH = 5'b11011,
      SEQ = 5'b11100, SLT = 5'b11101, SLE = 5'b11110, SCO = 5'b11111
   } opcodeT;

   // coarse grouping of the opcodes
   typedef enum logic [2:0] {
      CLS_SYS,       // halt, nop
      CLS_IFMT,      // reg op imm5
      CLS_RFMT,      // reg op reg
      CLS_MEM,       // st, ld, stu
      CLS_BRANCH,    // conditional on rs
      CLS_JUMP,      // j, jr, jal, jalr
      CLS_IMM,       // lbi, slbi
      CLS_ILLEGAL
   } opClassT;

endpackage

// ==== verilog/decode_cfg.svh ====
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// datapath word, every register and immediate is this wide
`define DATA_W 16

// register file geometry
`define NUM_REGS 8
`define REG_SEL_W 3   // log2 of NUM_REGS

// nop: opcode 00001 with every field zero
// replaces the fetched word while the valid level is low
`define NOP_INSTR 16'h0800

`endif
